//--- Makefile
# Verilator build and run for the JTAG debug port testbench

VERILATOR ?= verilator
TOP       ?= tb_jtag_wb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
GOLDEN    ?= jtag_golden.txt
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FLIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN) $(GOLDEN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
jtag_pkg.sv
wb_pkg.sv
jtag_ifs.sv
jtag_pad_sync.sv
jtag_tap.sv
jtag_wb_bridge.sv
wb_regfile.sv
jtag_wb_top.sv
jtag_wb_asserts.sv
tb_jtag_checker.sv
tb_jtag_wb.sv

//--- jtag_golden.txt
# test name  kind(ir|dr|reset)  bits  shift-in(hex)  expected shift-out(hex, - = not compared)
# reset lines: bits = TCK periods with TMS high, 0 = pulse i_trst_n
idcode_reset    dr     32  00000000    1beef0df
ir_capture      ir      4  f           5
bypass          ir      4  f           5
bypass          dr      9  0b5         16a
write_readback  ir      4  2           5
write_readback  dr     40  0000000000  -
write_readback  dr     40  85cafe1234  0000000000
write_readback  dr     40  8311111111  0000000000
write_readback  dr     40  8777777777  0000000000
write_readback  dr     40  0500000000  0000000000
write_readback  dr     40  0500000000  00cafe1234
tap_reset       ir      4  f           5
tap_reset       reset   5  0           -
tap_reset       dr     32  00000000    1beef0df
tap_reset       ir      4  f           5
tap_reset       reset   0  0           -
tap_reset       dr     32  00000000    1beef0df
tap_reset       ir      4  2           5
tap_reset       dr     40  0300000000  00cafe1234
tap_reset       dr     40  0500000000  0011111111
tap_reset       dr     40  0000000000  00cafe1234

//--- jtag_ifs.sv
// internal interfaces of the debug port
//   jtag_pad_if     synchronized pins and TCK edge strobes
//   jtag_status_if  TAP state towards the bridge
//   wb_if           Wishbone classic bus
`timescale 1ns/10ps

interface jtag_pad_if;
	logic	tck_rise;
	logic	tck_fall;
	logic	tms;
	logic	tdi;
	logic	trst;
	logic	tdo;

	modport source (output tck_rise, tck_fall, tms, tdi, trst, input tdo);
	modport sink   (input tck_rise, tck_fall, tms, tdi, trst, output tdo);
endinterface : jtag_pad_if

interface jtag_status_if import jtag_pkg::*, wb_pkg::*;;
	t_jtag_isr		ir;
	logic			capture_dr;
	logic			update_dr;
	t_jtag_dsr		dsr;
	t_bridge_word	rsp;

	modport master (output ir, capture_dr, update_dr, dsr, input rsp);
	modport slave  (input ir, capture_dr, update_dr, dsr, output rsp);
endinterface : jtag_status_if

interface wb_if import wb_pkg::*;;
	logic		cyc;
	logic		stb;
	logic		we;
	t_wb_addr	adr;
	t_wb_data	dat_w;
	logic		ack;
	t_wb_data	dat_r;

	modport master (output cyc, stb, we, adr, dat_w, input ack, dat_r);
	modport slave  (input cyc, stb, we, adr, dat_w, output ack, dat_r);
endinterface : wb_if

//--- jtag_pad_sync.sv
// JTAG pin synchronizer
// two-flop sync of TCK, TMS, TDI and TRST, TCK edge strobes, TDO output flop
`timescale 1ns/10ps

module jtag_pad_sync (
	input	logic	pads,
	input	logic	i_rst_n,
	input	logic	i_tck,
	input	logic	i_tms,
	input	logic	i_tdi,
	input	logic	i_trst_n,
	output	logic	o_tdo,
	jtag_pad_if.source	pad
);

	// pin order {trst_n, tms, tdi, tck}, idle levels
	localparam logic [3:0] C_PIN_IDLE = 4'b1100;

	logic [3:0]	pin_meta;
	logic [3:0]	pin_sync;
	logic		tck_prev;

	always_ff @(posedge pads) begin
		if (!i_rst_n) begin
			pin_meta	<= C_PIN_IDLE;
			pin_sync	<= C_PIN_IDLE;
			tck_prev	<= 1'b0;
			o_tdo		<= 1'b0;
		end else begin
			pin_meta	<= {i_trst_n, i_tms, i_tdi, i_tck};
			pin_sync	<= pin_meta;
			tck_prev	<= pin_sync[0];
			o_tdo		<= pad.tdo;
		end
	end

	// edge strobes, one pads cycle wide
	assign pad.tck_rise	= pin_sync[0] & ~tck_prev;
	assign pad.tck_fall	= ~pin_sync[0] & tck_prev;
	assign pad.tdi		= pin_sync[1];
	assign pad.tms		= pin_sync[2];
	assign pad.trst		= ~pin_sync[3];

endmodule : jtag_pad_sync

//--- jtag_pkg.sv
// JTAG TAP definitions
// state encoding, instruction codes and shift register widths

package jtag_pkg;

	// sixteen-state TAP controller
	typedef enum logic [3:0] {
		TS_RESET, TS_RUN,
		TS_SELECT_DR, TS_CAPTURE_DR, TS_SHIFT_DR, TS_EXIT1_DR,
		TS_PAUSE_DR, TS_EXIT2_DR, TS_UPDATE_DR,
		TS_SELECT_IR, TS_CAPTURE_IR, TS_SHIFT_IR, TS_EXIT1_IR,
		TS_PAUSE_IR, TS_EXIT2_IR, TS_UPDATE_IR
	} jtag_tap_states;

	// instruction register
	localparam int C_IR_LEN = 4;
	typedef logic [C_IR_LEN-1:0] t_jtag_isr;

	localparam t_jtag_isr IR_IDCODE = 4'b0001;
	localparam t_jtag_isr IR_WB_CMD = 4'b0010;
	localparam t_jtag_isr IR_BYPASS = 4'b1111;
	localparam t_jtag_isr C_IR_CAPTURE = 4'b0101;

	// data shift register
	localparam int C_DR_LEN = 40;
	typedef logic [C_DR_LEN-1:0] t_jtag_dsr;

endpackage : jtag_pkg

//--- jtag_tap.sv
// JTAG TAP controller
// state machine, instruction register, bypass and data shift registers, TDO latch
`timescale 1ns/10ps

module jtag_tap import jtag_pkg::*; #(
	parameter logic [31:0] P_IDCODE = 32'h1BEEF0DF
) (
	input	logic	pads,
	input	logic	i_rst_n,
	jtag_pad_if.sink		pad,
	jtag_status_if.master	status
);

	jtag_tap_states	tap_state, tap_state_nxt;
	t_jtag_isr		ir_reg, ir_shift;
	t_jtag_dsr		dr_shift;
	logic			bypass_reg;
	logic			tdo_latch;
	logic			dr_sel;
	logic			tap_rst;

	assign tap_rst = ~i_rst_n | pad.trst;

	// ----------------------------------------------------------------------
	// state machine
	always_ff @(posedge pads) begin
		if (tap_rst) begin
			tap_state <= TS_RESET;
		end else if (pad.tck_rise) begin
			tap_state <= tap_state_nxt;
		end
	end

	always_comb begin
		case (tap_state)
			TS_RESET:		tap_state_nxt = pad.tms ? TS_RESET     : TS_RUN;
			TS_RUN:			tap_state_nxt = pad.tms ? TS_SELECT_DR : TS_RUN;
			TS_SELECT_DR:	tap_state_nxt = pad.tms ? TS_SELECT_IR : TS_CAPTURE_DR;
			TS_CAPTURE_DR:	tap_state_nxt = pad.tms ? TS_EXIT1_DR  : TS_SHIFT_DR;
			TS_SHIFT_DR:	tap_state_nxt = pad.tms ? TS_EXIT1_DR  : TS_SHIFT_DR;
			TS_EXIT1_DR:	tap_state_nxt = pad.tms ? TS_UPDATE_DR : TS_PAUSE_DR;
			TS_PAUSE_DR:	tap_state_nxt = pad.tms ? TS_EXIT2_DR  : TS_PAUSE_DR;
			TS_EXIT2_DR:	tap_state_nxt = pad.tms ? TS_UPDATE_DR : TS_SHIFT_DR;
			TS_UPDATE_DR:	tap_state_nxt = pad.tms ? TS_SELECT_DR : TS_RUN;
			TS_SELECT_IR:	tap_state_nxt = pad.tms ? TS_RESET     : TS_CAPTURE_IR;
			TS_CAPTURE_IR:	tap_state_nxt = pad.tms ? TS_EXIT1_IR  : TS_SHIFT_IR;
			TS_SHIFT_IR:	tap_state_nxt = pad.tms ? TS_EXIT1_IR  : TS_SHIFT_IR;
			TS_EXIT1_IR:	tap_state_nxt = pad.tms ? TS_UPDATE_IR : TS_PAUSE_IR;
			TS_PAUSE_IR:	tap_state_nxt = pad.tms ? TS_EXIT2_IR  : TS_PAUSE_IR;
			TS_EXIT2_IR:	tap_state_nxt = pad.tms ? TS_UPDATE_IR : TS_SHIFT_IR;
			TS_UPDATE_IR:	tap_state_nxt = pad.tms ? TS_SELECT_DR : TS_RUN;
			default:		tap_state_nxt = TS_RESET;
		endcase
	end

	// unknown instructions fall back to bypass
	always_comb begin
		case (ir_reg)
			IR_IDCODE, IR_WB_CMD:	dr_sel = 1'b1;
			IR_BYPASS:				dr_sel = 1'b0;
			default:				dr_sel = 1'b0;
		endcase
	end

	// ----------------------------------------------------------------------
	// instruction register, test-logic-reset returns it to IDCODE
	always_ff @(posedge pads) begin
		if (tap_rst) begin
			ir_reg		<= IR_IDCODE;
			ir_shift	<= '0;
		end else if (pad.tck_rise) begin
			if (tap_state == TS_RESET)
				ir_reg <= IR_IDCODE;
			if (tap_state == TS_UPDATE_IR)
				ir_reg <= ir_shift;
			if (tap_state == TS_CAPTURE_IR)
				ir_shift <= C_IR_CAPTURE;
			if (tap_state == TS_SHIFT_IR)
				ir_shift <= {pad.tdi, ir_shift[C_IR_LEN-1:1]};
		end
	end

	// bypass bit and DR, LSB out first and TDI in at the MSB
	always_ff @(posedge pads) begin
		if (pad.tck_rise) begin
			if (tap_state == TS_CAPTURE_DR) begin
				bypass_reg	<= 1'b0;
				dr_shift	<= (ir_reg == IR_WB_CMD) ? t_jtag_dsr'(status.rsp)
													 : t_jtag_dsr'(P_IDCODE);
			end
			if (tap_state == TS_SHIFT_DR) begin
				bypass_reg	<= pad.tdi;
				dr_shift	<= {pad.tdi, dr_shift[C_DR_LEN-1:1]};
			end
		end
	end

	// ----------------------------------------------------------------------
	// TDO latch, updated on the falling TCK edge
	always_ff @(posedge pads) begin
		if (tap_rst) begin
			tdo_latch <= 1'b0;
		end else if (pad.tck_fall) begin
			if (tap_state == TS_SHIFT_IR)
				tdo_latch <= ir_shift[0];
			else if (tap_state == TS_SHIFT_DR)
				tdo_latch <= dr_sel ? dr_shift[0] : bypass_reg;
			else
				tdo_latch <= 1'b0;
		end
	end

	assign pad.tdo = tdo_latch;

	// strobes for the bridge, aligned to the edge leaving the state
	assign status.capture_dr	= pad.tck_rise & (tap_state == TS_CAPTURE_DR);
	assign status.update_dr		= pad.tck_rise & (tap_state == TS_UPDATE_DR);
	assign status.ir			= ir_reg;
	assign status.dsr			= dr_shift;

endmodule : jtag_tap

//--- jtag_wb_asserts.sv
// concurrent checks on the TAP reset state and the Wishbone handshake
`timescale 1ns/10ps

module jtag_wb_asserts import jtag_pkg::*; (
	input	logic		pads,
	input	logic		i_rst_n,
	input	logic		i_cyc,
	input	logic		i_stb,
	input	logic		i_ack,
	input	logic [3:0]	i_tap_state
);

	// failed assertions so far
	int fail_cnt = 0;

	// ack only inside an active cycle
	a_ack_in_stb: assert property (@(posedge pads) disable iff (!i_rst_n)
		i_ack |-> (i_stb && i_cyc))
		else begin
			$error("wishbone ack outside stb");
			fail_cnt++;
		end

	// master holds the strobe until the slave answers
	a_stb_hold: assert property (@(posedge pads) disable iff (!i_rst_n)
		(i_stb && !i_ack) |=> i_stb)
		else begin
			$error("wishbone stb dropped before ack");
			fail_cnt++;
		end

	a_tap_reset: assert property (@(posedge pads)
		!i_rst_n |=> (i_tap_state == TS_RESET))
		else begin
			$error("TAP not in test-logic-reset after reset");
			fail_cnt++;
		end

endmodule : jtag_wb_asserts

bind jtag_wb_top jtag_wb_asserts u_asserts (
	.pads			(pads),
	.i_rst_n		(i_rst_n),
	.i_cyc			(wb_bus.cyc),
	.i_stb			(wb_bus.stb),
	.i_ack			(wb_bus.ack),
	.i_tap_state	(u_tap.tap_state)
);

//--- jtag_wb_bridge.sv
// JTAG to Wishbone bridge
// turns an updated command word into one classic bus cycle
// and keeps busy, err and read data for the next capture
`timescale 1ns/10ps

module jtag_wb_bridge import jtag_pkg::*, wb_pkg::*; (
	input	logic	pads,
	input	logic	i_rst_n,
	jtag_status_if.slave	status,
	wb_if.master			wb
);

	t_bridge_word	cmd_word;
	t_bridge_word	rsp_word;
	logic			wb_cmd_sel;
	logic			busy;
	logic			err;
	t_wb_data		rdata;

	assign cmd_word		= status.dsr;
	assign wb_cmd_sel	= (status.ir == IR_WB_CMD);

	// ----------------------------------------------------------------------
	// bus cycle control
	always_ff @(posedge pads) begin
		if (!i_rst_n) begin
			busy	<= 1'b0;
			err		<= 1'b0;
		end else begin
			if (wb_cmd_sel && status.update_dr) begin
				// a command during a running cycle is dropped
				if (busy)
					err <= 1'b1;
				else
					busy <= 1'b1;
			end else if (busy && wb.ack) begin
				busy <= 1'b0;
			end
			if (wb_cmd_sel && status.capture_dr)
				err <= 1'b0;
		end
	end

	// address, data and read result
	always_ff @(posedge pads) begin
		if (wb_cmd_sel && status.update_dr && !busy) begin
			wb.we		<= cmd_word.cmd.we;
			wb.adr		<= cmd_word.cmd.adr;
			wb.dat_w	<= cmd_word.cmd.dat;
		end
		if (busy && wb.ack && !wb.we)
			rdata <= wb.dat_r;
	end

	assign wb.cyc = busy;
	assign wb.stb = busy;

	// ----------------------------------------------------------------------
	// response view for the next capture
	always_comb begin
		rsp_word			= '0;
		rsp_word.rsp.busy	= busy;
		rsp_word.rsp.err	= err;
		rsp_word.rsp.rdat	= rdata;
	end

	assign status.rsp = rsp_word;

endmodule : jtag_wb_bridge

//--- jtag_wb_top.sv
// JTAG debug port top level
// pin sync, TAP, Wishbone bridge and register file
`timescale 1ns/10ps

module jtag_wb_top #(
	parameter logic [31:0]	P_IDCODE	= 32'h1BEEF0DF,
	parameter int			P_DEPTH		= 16
) (
	input	logic	pads,
	input	logic	i_rst_n,
	input	logic	i_tck,
	input	logic	i_tms,
	input	logic	i_tdi,
	input	logic	i_trst_n,
	output	logic	o_tdo
);

	jtag_pad_if		pad_if ();
	jtag_status_if	status_if ();
	wb_if			wb_bus ();

	jtag_pad_sync u_pad_sync (
		.pads		(pads),
		.i_rst_n	(i_rst_n),
		.i_tck		(i_tck),
		.i_tms		(i_tms),
		.i_tdi		(i_tdi),
		.i_trst_n	(i_trst_n),
		.o_tdo		(o_tdo),
		.pad		(pad_if.source)
	);

	jtag_tap #(.P_IDCODE(P_IDCODE)) u_tap (
		.pads		(pads),
		.i_rst_n	(i_rst_n),
		.pad		(pad_if.sink),
		.status		(status_if.master)
	);

	jtag_wb_bridge u_bridge (
		.pads		(pads),
		.i_rst_n	(i_rst_n),
		.status		(status_if.slave),
		.wb			(wb_bus.master)
	);

	wb_regfile #(.P_DEPTH(P_DEPTH)) u_regfile (
		.pads		(pads),
		.i_rst_n	(i_rst_n),
		.wb			(wb_bus.slave)
	);

endmodule : jtag_wb_top

//--- tb_jtag_checker.sv
// scan checker for the JTAG testbench
// collects o_tdo bits during shifts and compares each scan with its golden word
// prints one line per test and the counts at the end
`timescale 1ns/10ps

module tb_jtag_checker #(
	parameter int P_WORD_W = 40
) (
	input	logic					i_clk,
	input	logic					i_tdo,
	input	logic					i_scan_start,
	input	logic					i_sample,
	input	logic					i_scan_end,
	input	logic					i_test_end,
	input	logic					i_run_done,
	input	logic					i_check,
	input	string					i_test_name,
	input	logic [P_WORD_W-1:0]	i_exp_word,
	input	int						i_exp_len,
	output	int						o_test_count,
	output	int						o_fail_count
);

	logic [P_WORD_W-1:0]	got = '0;
	int						bit_idx = 0;
	int						test_errs = 0;
	int						test_count = 0;
	int						fail_count = 0;

	assign o_test_count = test_count;
	assign o_fail_count = fail_count;

	task automatic compare_scan();
		logic [P_WORD_W-1:0] mask;
		mask = '1 >> (P_WORD_W - i_exp_len);
		if (bit_idx != i_exp_len) begin
			$display("scan in %0s sampled %0d bits of o_tdo instead of %0d",
				i_test_name, bit_idx, i_exp_len);
			test_errs++;
		end else if (i_check && (got & mask) != (i_exp_word & mask)) begin
			$display("error at %0d ns: o_tdo shifted out %0h, expected %0h (%0s)",
				$time, got & mask, i_exp_word & mask, i_test_name);
			test_errs++;
		end
	endtask

	task automatic report_test();
		test_count++;
		if (test_errs == 0) begin
			$display("pass  %0s", i_test_name);
		end else begin
			$display("FAIL  %0s  %0d bad scans", i_test_name, test_errs);
			fail_count++;
		end
		test_errs = 0;
	endtask

	always @(posedge i_clk) begin
		if (i_scan_start) begin
			got = '0;
			bit_idx = 0;
		end
		// LSB leaves first
		if (i_sample) begin
			if (bit_idx < P_WORD_W)
				got[bit_idx] = i_tdo;
			bit_idx++;
		end
		if (i_scan_end)
			compare_scan();
		if (i_test_end)
			report_test();
		if (i_run_done)
			$display("%0d tests run, %0d passed, %0d failed",
				test_count, test_count - fail_count, fail_count);
	end

endmodule : tb_jtag_checker

//--- tb_jtag_wb.sv
// testbench for the JTAG debug port
//   tb_clock_gen  pads clock source
//   tb_jtag_wb    golden file reader, JTAG pin driver and watchdog
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int P_HALF_NS = 20
) (
	output	logic	o_clk
);

	initial begin
		o_clk = 1'b0;
		forever #(P_HALF_NS) o_clk = ~o_clk;
	end

endmodule : tb_clock_gen

module tb_jtag_wb;

	localparam logic [31:0]	C_IDCODE	= 32'h1BEEF0DF;
	localparam int			C_CLK_NS	= 40;
	localparam int			C_TCK_DIV	= 8;
	localparam int			C_TCK_NS	= C_CLK_NS * C_TCK_DIV;
	localparam int			C_WORD_W	= 40;
	localparam int			C_WD_TCKS	= 60;
	localparam string		C_GOLDEN	= "jtag_golden.txt";

	logic	pads;
	logic	rst_n;
	logic	tck;
	logic	tms;
	logic	tdi;
	logic	trst_n;
	logic	tdo;

	// handshake towards the checker
	logic					scan_start;
	logic					sample;
	logic					scan_end;
	logic					test_end;
	logic					run_done;
	logic					chk_on;
	string					test_name;
	logic [C_WORD_W-1:0]	exp_word;
	int						exp_len;
	int						test_count;
	int						fail_count;

	// golden lines
	string					q_name[$];
	string					q_kind[$];
	int						q_len[$];
	logic [C_WORD_W-1:0]	q_din[$];
	logic [C_WORD_W-1:0]	q_dout[$];
	bit						q_check[$];
	int						n_lines = 0;

	tb_clock_gen #(.P_HALF_NS(C_CLK_NS / 2)) clk0 (
		.o_clk	(pads)
	);

	jtag_wb_top #(
		.P_IDCODE	(C_IDCODE),
		.P_DEPTH	(16)
	) dut0 (
		.pads		(pads),
		.i_rst_n	(rst_n),
		.i_tck		(tck),
		.i_tms		(tms),
		.i_tdi		(tdi),
		.i_trst_n	(trst_n),
		.o_tdo		(tdo)
	);

	tb_jtag_checker #(.P_WORD_W(C_WORD_W)) chk0 (
		.i_clk			(pads),
		.i_tdo			(tdo),
		.i_scan_start	(scan_start),
		.i_sample		(sample),
		.i_scan_end		(scan_end),
		.i_test_end		(test_end),
		.i_run_done		(run_done),
		.i_check		(chk_on),
		.i_test_name	(test_name),
		.i_exp_word		(exp_word),
		.i_exp_len		(exp_len),
		.o_test_count	(test_count),
		.o_fail_count	(fail_count)
	);

	// ----------------------------------------------------------------------
	// pin driver, inputs change 2 ns after the pads edge
	task automatic next_slot();
		@(posedge pads);
		#2;
	endtask

	// one TCK period, low half then high half
	task automatic tck_period(input logic tms_v, input logic tdi_v, input logic smp);
		tck = 1'b0;
		tms = tms_v;
		tdi = tdi_v;
		repeat (C_TCK_DIV / 2) next_slot();
		// o_tdo has settled from the falling edge by now
		tck = 1'b1;
		sample = smp;
		next_slot();
		sample = 1'b0;
		repeat (C_TCK_DIV / 2 - 1) next_slot();
	endtask

	// from run-test/idle through shift and back to run-test/idle
	task automatic shift_scan(input logic is_ir, input int len, input logic [C_WORD_W-1:0] din);
		tck_period(1'b1, 1'b0, 1'b0);
		if (is_ir)
			tck_period(1'b1, 1'b0, 1'b0);
		// capture, then shift
		tck_period(1'b0, 1'b0, 1'b0);
		tck_period(1'b0, 1'b0, 1'b0);
		for (int i = 0; i < len; i++)
			tck_period(i == len - 1, din[i], 1'b1);
		// exit1 to update, update to idle
		tck_period(1'b1, 1'b0, 1'b0);
		tck_period(1'b0, 1'b0, 1'b0);
	endtask

	// n_tms periods with TMS high, or a TRST pulse when n_tms is 0
	task automatic reset_tap(input int n_tms);
		if (n_tms > 0) begin
			repeat (n_tms) tck_period(1'b1, 1'b0, 1'b0);
		end else begin
			trst_n = 1'b0;
			repeat (C_TCK_DIV) next_slot();
			trst_n = 1'b1;
			repeat (C_TCK_DIV) next_slot();
		end
		tck_period(1'b0, 1'b0, 1'b0);
	endtask

	task automatic run_line(input int idx);
		test_name = q_name[idx];
		if (q_kind[idx] == "reset") begin
			reset_tap(q_len[idx]);
		end else begin
			exp_word = q_dout[idx];
			exp_len = q_len[idx];
			chk_on = q_check[idx];
			scan_start = 1'b1;
			next_slot();
			scan_start = 1'b0;
			shift_scan(q_kind[idx] == "ir", q_len[idx], q_din[idx]);
			scan_end = 1'b1;
			next_slot();
			scan_end = 1'b0;
		end
	endtask

	// ----------------------------------------------------------------------
	// golden file, one scan per line
	task automatic load_golden(output bit ok);
		int						fd;
		int						cnt;
		int						len_v;
		string					text;
		string					name_s;
		string					kind_s;
		string					exp_s;
		logic [C_WORD_W-1:0]	din_v;
		logic [C_WORD_W-1:0]	dout_v;
		ok = 1'b1;
		fd = $fopen(C_GOLDEN, "r");
		if (fd == 0) begin
			$display("cannot open %s for reading", C_GOLDEN);
			ok = 1'b0;
		end else begin
			while ($fgets(text, fd) > 0) begin
				if (text.len() == 0 || text.getc(0) == "#")
					continue;
				cnt = $sscanf(text, "%s %s %d %h %s", name_s, kind_s, len_v, din_v, exp_s);
				if (cnt != 5)
					continue;
				if ((kind_s != "ir" && kind_s != "dr" && kind_s != "reset") || len_v > C_WORD_W) begin
					$display("golden line not understood: %s", text);
					ok = 1'b0;
					continue;
				end
				dout_v = '0;
				if (exp_s != "-")
					cnt = $sscanf(exp_s, "%h", dout_v);
				q_name.push_back(name_s);
				q_kind.push_back(kind_s);
				q_len.push_back(len_v);
				q_din.push_back(din_v);
				q_dout.push_back(dout_v);
				q_check.push_back(exp_s != "-");
			end
			$fclose(fd);
			if (q_name.size() == 0) begin
				$display("no scans found in %s", C_GOLDEN);
				ok = 1'b0;
			end
		end
	endtask

	// ----------------------------------------------------------------------
	initial begin
		bit ok;
		rst_n = 1'b0;
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		trst_n = 1'b1;
		scan_start = 1'b0;
		sample = 1'b0;
		scan_end = 1'b0;
		test_end = 1'b0;
		run_done = 1'b0;
		chk_on = 1'b0;
		test_name = "";
		exp_word = '0;
		exp_len = 0;
		load_golden(ok);
		if (!ok) begin
			$display("test failed");
			$finish;
		end else begin
			n_lines = q_name.size();
			repeat (4) @(posedge pads);
			#2;
			rst_n = 1'b1;
			// leave test-logic-reset
			tck_period(1'b0, 1'b0, 1'b0);
			for (int i = 0; i < n_lines; i++) begin
				run_line(i);
				if (i == n_lines - 1 || q_name[i + 1] != q_name[i]) begin
					test_end = 1'b1;
					next_slot();
					test_end = 1'b0;
				end
			end
			run_done = 1'b1;
			next_slot();
			run_done = 1'b0;
			next_slot();
			if (dut0.u_asserts.fail_cnt != 0)
				$display("%0d assertion failures in the DUT", dut0.u_asserts.fail_cnt);
			if (fail_count == 0 && test_count > 0 && dut0.u_asserts.fail_cnt == 0)
				$display("test passed");
			else
				$display("test failed");
			$finish;
		end
	end

	// watchdog, scaled by the number of golden lines
	initial begin
		wait (n_lines > 0);
		#(n_lines * C_WD_TCKS * C_TCK_NS);
		$display("run timed out after %0d TCK periods", n_lines * C_WD_TCKS);
		$display("test failed");
		$finish;
	end

endmodule : tb_jtag_wb

//--- wb_pkg.sv
// Wishbone bus widths and the bridge word layout
// one 40-bit word, read as a command or as a response

package wb_pkg;

	localparam int C_WB_AW = 4;
	localparam int C_WB_DW = 32;

	typedef logic [C_WB_AW-1:0] t_wb_addr;
	typedef logic [C_WB_DW-1:0] t_wb_data;

	// shifted in by the host
	typedef struct packed {
		logic		we;
		logic [2:0]	rsvd;
		t_wb_addr	adr;
		t_wb_data	dat;
	} t_bridge_cmd;

	// captured and shifted out
	typedef struct packed {
		logic		busy;
		logic		err;
		logic [5:0]	rsvd;
		t_wb_data	rdat;
	} t_bridge_rsp;

	typedef union packed {
		t_bridge_cmd	cmd;
		t_bridge_rsp	rsp;
	} t_bridge_word;

endpackage : wb_pkg

//--- wb_regfile.sv
// Wishbone classic slave register file
// P_DEPTH words of 32 bits, registered read data, single-cycle ack
`timescale 1ns/10ps

module wb_regfile import wb_pkg::*; #(
	parameter int P_DEPTH = 16
) (
	input	logic	pads,
	input	logic	i_rst_n,
	wb_if.slave		wb
);

	localparam int C_IDX_W = $clog2(P_DEPTH);

	t_wb_data				regs [P_DEPTH];
	logic [C_IDX_W-1:0]		idx;
	logic					hit;
	logic					req;

	assign idx	= wb.adr[C_IDX_W-1:0];
	assign hit	= (32'(wb.adr) < P_DEPTH);
	// new request, ack not yet given
	assign req	= wb.cyc & wb.stb & ~wb.ack;

	always_ff @(posedge pads) begin
		if (!i_rst_n) begin
			wb.ack <= 1'b0;
			for (int i = 0; i < P_DEPTH; i++)
				regs[i] <= '0;
		end else begin
			wb.ack <= req;
			if (req && wb.we && hit)
				regs[idx] <= wb.dat_w;
		end
	end

	// unmapped addresses read as zero
	always_ff @(posedge pads) begin
		if (req)
			wb.dat_r <= hit ? regs[idx] : '0;
	end

endmodule : wb_regfile
